// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= minimac_tb
FILELIST  ?= minimac.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the status of the recipe is the status of the search for the pass line
run: compile
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/minimac_tb.sv
////////////////////
// minimac testbench
// directed tests of the receive mac: csr access, mii
// frames, filtering, drops and back to back frames
////////////////////
`default_nettype none

module minimac_tb;
	import minimac_pkg::*;

	localparam logic [3:0] CSR_BLOCK = 4'h3;
	localparam int TIMEOUT_CYCLES = 40000;
	// minimum inter frame gap, 96 bit times
	localparam int IFG_NIBBLES = 24;
	localparam int IRQ_BOUND = 1000;
	localparam int POLL_BOUND = 500;
	localparam logic [47:0] STATION = 48'h0012_3456_789a;
	localparam logic [47:0] OTHER = 48'h02aa_bbcc_ddee;

	typedef logic [7:0] byte_q_t[$];

	logic sys_clk;
	logic phy_rx_clk;
	logic reset;
	csr_addr_t csr_a;
	logic csr_we;
	csr_data_t csr_di;
	csr_data_t csr_do;
	logic irq_rx;
	logic [31:0] wbm_adr;
	logic wbm_stb;
	logic wbm_ack;
	logic [31:0] wbm_dat;
	logic [3:0] phy_rx_data;
	logic phy_dv;
	logic phy_rx_er;

	// wishbone memory, keyed by word address
	logic [31:0] mem [logic [29:0]];
	int errors;
	int checks;
	int tests;
	int errors_at_start;
	int cycle_count;

	minimac #(
		.csr_addr(CSR_BLOCK)
	) dut_i (
		.sys_clk(sys_clk),
		.reset_i(reset),
		.csr_a_i(csr_a),
		.csr_we_i(csr_we),
		.csr_di_i(csr_di),
		.csr_do_o(csr_do),
		.irq_rx_o(irq_rx),
		.wbm_adr_o(wbm_adr),
		.wbm_stb_o(wbm_stb),
		.wbm_ack_i(wbm_ack),
		.wbm_dat_o(wbm_dat),
		.phy_rx_clk(phy_rx_clk),
		.phy_rx_data_i(phy_rx_data),
		.phy_dv_i(phy_dv),
		.phy_rx_er_i(phy_rx_er)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	initial begin
		phy_rx_clk = 1'b0;
		forever #80 phy_rx_clk = ~phy_rx_clk;
	end

	// run limit, about six long frames plus slack
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge sys_clk);
			cycle_count++;
		end
		$display("timeout: run stopped after %0d sys_clk cycles", TIMEOUT_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	// slave acks each write after 0 to 3 idle cycles
	initial begin
		int unsigned wait_cycles;
		wbm_ack = 1'b0;
		forever begin
			@(posedge sys_clk);
			#10;
			if (wbm_stb) begin
				wait_cycles = $urandom % 4;
				repeat (wait_cycles) begin
					@(posedge sys_clk);
					#10;
				end
				mem[wbm_adr[31:2]] = wbm_dat;
				wbm_ack = 1'b1;
				@(posedge sys_clk);
				#10;
				wbm_ack = 1'b0;
			end
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	task automatic start_test();
		errors_at_start = errors;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %s: %0d errors", name, errors - errors_at_start);
	endtask

	task automatic csr_write(input logic [3:0] idx, input logic [31:0] val);
		@(posedge sys_clk);
		#10;
		csr_a = {CSR_BLOCK, 6'd0, idx};
		csr_di = val;
		csr_we = 1'b1;
		@(posedge sys_clk);
		#10;
		csr_we = 1'b0;
	endtask

	// read data is registered, valid one cycle after the address
	task automatic csr_read(input logic [3:0] idx, output logic [31:0] val);
		@(posedge sys_clk);
		#10;
		csr_a = {CSR_BLOCK, 6'd0, idx};
		csr_we = 1'b0;
		@(posedge sys_clk);
		#10;
		val = csr_do;
	endtask

	// destination msb byte first, then random source and payload
	function automatic byte_q_t make_frame(input logic [47:0] dest, input int len);
		byte_q_t q;
		int i;
		for (i = 0; i < 6; i++)
			q.push_back(dest[47 - 8 * i -: 8]);
		for (i = 6; i < len; i++)
			q.push_back(8'($urandom));
		return q;
	endfunction

	// little endian packing, missing tail bytes read as zero
	function automatic logic [31:0] pack_word(input byte_q_t q, input int w);
		logic [31:0] v;
		int k;
		v = '0;
		for (k = 0; k < 4; k++)
			if (4 * w + k < q.size())
				v[8 * k +: 8] = q[4 * w + k];
		return v;
	endfunction

	function automatic int word_count(input byte_q_t q);
		return (q.size() + 3) / 4;
	endfunction

	// er_nibble < 0 sends a clean frame
	task automatic send_frame(input byte_q_t data, input int er_nibble);
		int i;
		@(posedge phy_rx_clk);
		#10;
		phy_dv = 1'b1;
		for (i = 0; i < 15; i++) begin
			phy_rx_data = 4'h5;
			@(posedge phy_rx_clk);
			#10;
		end
		// delimiter 0xd5, low nibble went out as the last 5
		phy_rx_data = 4'hd;
		@(posedge phy_rx_clk);
		#10;
		for (i = 0; i < 2 * data.size(); i++) begin
			phy_rx_data = i[0] ? data[i / 2][7:4] : data[i / 2][3:0];
			phy_rx_er = (i == er_nibble);
			@(posedge phy_rx_clk);
			#10;
		end
		phy_dv = 1'b0;
		phy_rx_er = 1'b0;
		phy_rx_data = 4'h0;
		repeat (IFG_NIBBLES) @(posedge phy_rx_clk);
	endtask

	task automatic wait_irq(input int max_cycles);
		int n;
		n = 0;
		do begin
			@(posedge sys_clk);
			#10;
			n++;
		end while (!irq_rx && n < max_cycles);
		if (!irq_rx)
			note_failure($sformatf("irq_rx did not rise within %0d cycles", max_cycles));
	endtask

	// polls the drop counter until it reaches the expected value
	task automatic wait_drops(input int expected);
		logic [31:0] v;
		int n;
		n = 0;
		do begin
			csr_read(REG_DROPS, v);
			n++;
		end while (v != expected && n < POLL_BOUND);
		check("drops", v, expected);
	endtask

	task automatic check_slot(input logic [29:0] base, input byte_q_t frame);
		int w;
		logic [29:0] a;
		for (w = 0; w < word_count(frame); w++) begin
			a = base + 30'(w);
			if (mem.exists(a))
				check($sformatf("mem[0x%h]", a), mem[a], pack_word(frame, w));
			else
				note_failure($sformatf("no write reached word address 0x%h", a));
		end
	endtask

	task automatic test_registers();
		logic [31:0] v;
		start_test();
		check("wbm_stb", 32'(wbm_stb), 32'h0);
		check("irq_rx", 32'(irq_rx), 32'h0);
		csr_read(REG_DROPS, v);
		check("drops", v, 32'h0);
		csr_read(REG_CTRL, v);
		check("ctrl", v, 32'h0);
		csr_read(REG_STATUS, v);
		check("status", v, 32'h0);
		csr_write(REG_MAC_HI, {16'h0, STATION[47:32]});
		csr_write(REG_MAC_LO, STATION[31:0]);
		csr_write(REG_CTRL, 32'h2);
		csr_read(REG_CTRL, v);
		check("ctrl", v, 32'h2);
		csr_write(REG_CTRL, 32'h0);
		csr_write(REG_SLOT_ADR, 32'h100);
		csr_read(REG_MAC_HI, v);
		check("mac_hi", v, {16'h0, STATION[47:32]});
		csr_read(REG_MAC_LO, v);
		check("mac_lo", v, STATION[31:0]);
		csr_read(REG_CTRL, v);
		check("ctrl", v, 32'h0);
		csr_read(REG_SLOT_ADR, v);
		check("slot_adr", v, 32'h100);
		// slot armed, no frame done yet
		csr_read(REG_STATUS, v);
		check("status", v, 32'h1);
		end_test("registers");
	endtask

	task automatic test_unicast();
		byte_q_t frame;
		logic [31:0] v;
		start_test();
		frame = make_frame(STATION, 70);
		mem.delete();
		send_frame(frame, -1);
		wait_irq(IRQ_BOUND);
		csr_read(REG_COUNT, v);
		check("count", v, 32'd70);
		check_slot(30'h100, frame);
		check("words written", 32'(mem.num()), 32'(word_count(frame)));
		csr_write(REG_STATUS, 32'h2);
		check("irq_rx", 32'(irq_rx), 32'h0);
		csr_read(REG_STATUS, v);
		check("status", v, 32'h0);
		end_test("unicast");
	endtask

	task automatic test_filtering();
		byte_q_t frame;
		logic [31:0] v;
		int drops;
		start_test();
		csr_read(REG_DROPS, v);
		drops = v;
		csr_write(REG_SLOT_ADR, 32'h200);
		// foreign destination is popped and thrown away
		frame = make_frame(OTHER, 64);
		mem.delete();
		send_frame(frame, -1);
		wait_drops(drops + 1);
		check("irq_rx", 32'(irq_rx), 32'h0);
		check("words written", 32'(mem.num()), 32'h0);
		// same frame with promiscuous mode on
		csr_write(REG_CTRL, 32'h2);
		send_frame(frame, -1);
		wait_irq(IRQ_BOUND);
		check_slot(30'h200, frame);
		check("words written", 32'(mem.num()), 32'(word_count(frame)));
		csr_write(REG_STATUS, 32'h2);
		csr_write(REG_CTRL, 32'h0);
		// broadcast passes without promisc
		csr_write(REG_SLOT_ADR, 32'h300);
		frame = make_frame(48'hffff_ffff_ffff, 60);
		mem.delete();
		send_frame(frame, -1);
		wait_irq(IRQ_BOUND);
		check_slot(30'h300, frame);
		check("words written", 32'(mem.num()), 32'(word_count(frame)));
		csr_read(REG_COUNT, v);
		check("count", v, 32'd60);
		csr_write(REG_STATUS, 32'h2);
		csr_read(REG_DROPS, v);
		check("drops", v, 32'(drops + 1));
		end_test("filtering");
	endtask

	task automatic test_drops();
		byte_q_t frame;
		logic [31:0] v;
		int drops;
		start_test();
		csr_read(REG_DROPS, v);
		drops = v;
		frame = make_frame(STATION, 64);
		mem.delete();
		// no slot armed
		send_frame(frame, -1);
		wait_drops(drops + 1);
		// error in the first byte, before any word leaves
		csr_write(REG_SLOT_ADR, 32'h400);
		send_frame(frame, 2);
		wait_drops(drops + 2);
		// receiver held in reset by software
		csr_write(REG_CTRL, 32'h1);
		send_frame(frame, -1);
		wait_drops(drops + 3);
		csr_write(REG_CTRL, 32'h0);
		check("irq_rx", 32'(irq_rx), 32'h0);
		check("words written", 32'(mem.num()), 32'h0);
		csr_read(REG_STATUS, v);
		check("status", v, 32'h1);
		end_test("drops");
	endtask

	task automatic test_back_to_back();
		byte_q_t first;
		byte_q_t second;
		logic [31:0] v;
		int drops;
		start_test();
		first = make_frame(STATION, 64);
		second = make_frame(48'hffff_ffff_ffff, 72);
		mem.delete();
		// slot at 0x400 is still armed, next one armed between the frames
		fork
			begin
				send_frame(first, -1);
				send_frame(second, -1);
			end
			begin
				wait_irq(IRQ_BOUND);
				csr_write(REG_SLOT_ADR, 32'h500);
				csr_write(REG_STATUS, 32'h2);
				wait_irq(IRQ_BOUND);
			end
		join
		check_slot(30'h400, first);
		check_slot(30'h500, second);
		check("words written", 32'(mem.num()), 32'(word_count(first) + word_count(second)));
		csr_read(REG_COUNT, v);
		check("count", v, 32'd72);
		csr_write(REG_STATUS, 32'h2);
		// without a re-arm the second frame is lost
		csr_read(REG_DROPS, v);
		drops = v;
		csr_write(REG_SLOT_ADR, 32'h600);
		mem.delete();
		send_frame(first, -1);
		send_frame(second, -1);
		wait_irq(IRQ_BOUND);
		wait_drops(drops + 1);
		check_slot(30'h600, first);
		check("words written", 32'(mem.num()), 32'(word_count(first)));
		csr_read(REG_COUNT, v);
		check("count", v, 32'd64);
		csr_write(REG_STATUS, 32'h2);
		end_test("back_to_back");
	endtask

	initial begin
		void'($urandom(32'hd378_00a4));
		errors = 0;
		checks = 0;
		tests = 0;
		reset = 1'b1;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		phy_rx_data = 4'h0;
		phy_dv = 1'b0;
		phy_rx_er = 1'b0;
		repeat (16) @(posedge sys_clk);
		#10;
		reset = 1'b0;
		// let the phy side reset synchronizer settle
		repeat (4) @(posedge sys_clk);
		test_registers();
		test_unicast();
		test_filtering();
		test_drops();
		test_back_to_back();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/minimac.sv
////////////////////
// minimac receive mac, top level
// control interface, receive engine, clock crossing
// fifo and mii framer
////////////////////
`default_nettype none

module minimac #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input wire logic sys_clk,
	input wire logic reset_i,

	input wire minimac_pkg::csr_addr_t csr_a_i,
	input wire logic csr_we_i,
	input wire minimac_pkg::csr_data_t csr_di_i,
	output minimac_pkg::csr_data_t csr_do_o,

	output logic irq_rx_o,

	output logic [31:0] wbm_adr_o,
	output logic wbm_stb_o,
	input wire logic wbm_ack_i,
	output logic [31:0] wbm_dat_o,

	input wire logic phy_rx_clk,
	input wire logic [3:0] phy_rx_data_i,
	input wire logic phy_dv_i,
	input wire logic phy_rx_er_i
);
	import minimac_pkg::*;

	// control to engine
	logic rx_rst;
	logic promisc;
	mac_addr_t macaddr;
	logic rx_valid;
	word_addr_t rx_adr;
	// engine events
	logic rx_resetcount;
	logic rx_incrcount;
	logic rx_endframe;
	logic rx_drop;
	// fifo, write side in phy_rx_clk, read side in sys_clk
	logic fifo_wr_en;
	fifo_entry_t fifo_wr_data;
	logic fifo_full;
	logic fifo_rd_en;
	fifo_entry_t fifo_rd_data;
	logic fifo_empty;

	minimac_ctlif #(
		.csr_addr(csr_addr)
	) ctlif (
		.sys_clk(sys_clk),
		.reset_i(reset_i),
		.csr_a_i(csr_a_i),
		.csr_we_i(csr_we_i),
		.csr_di_i(csr_di_i),
		.csr_do_o(csr_do_o),
		.irq_rx_o(irq_rx_o),
		.rx_rst_o(rx_rst),
		.promisc_o(promisc),
		.macaddr_o(macaddr),
		.rx_valid_o(rx_valid),
		.rx_adr_o(rx_adr),
		.rx_resetcount_i(rx_resetcount),
		.rx_incrcount_i(rx_incrcount),
		.rx_endframe_i(rx_endframe),
		.rx_drop_i(rx_drop)
	);

	minimac_rx rx (
		.sys_clk(sys_clk),
		.reset_i(reset_i),
		.rx_rst_i(rx_rst),
		.promisc_i(promisc),
		.macaddr_i(macaddr),
		.rx_valid_i(rx_valid),
		.rx_adr_i(rx_adr),
		.empty_i(fifo_empty),
		.rd_data_i(fifo_rd_data),
		.rd_en_o(fifo_rd_en),
		.rx_resetcount_o(rx_resetcount),
		.rx_incrcount_o(rx_incrcount),
		.rx_endframe_o(rx_endframe),
		.rx_drop_o(rx_drop),
		.wbm_adr_o(wbm_adr_o),
		.wbm_stb_o(wbm_stb_o),
		.wbm_ack_i(wbm_ack_i),
		.wbm_dat_o(wbm_dat_o)
	);

	minimac_rx_fifo rx_fifo (
		.wr_clk(phy_rx_clk),
		.rd_clk(sys_clk),
		.reset_i(reset_i),
		.wr_en_i(fifo_wr_en),
		.wr_data_i(fifo_wr_data),
		.full_o(fifo_full),
		.rd_en_i(fifo_rd_en),
		.empty_o(fifo_empty),
		.rd_data_o(fifo_rd_data)
	);

	minimac_rx_framer rx_framer (
		.phy_rx_clk(phy_rx_clk),
		.reset_i(reset_i),
		.phy_rx_data_i(phy_rx_data_i),
		.phy_dv_i(phy_dv_i),
		.phy_rx_er_i(phy_rx_er_i),
		.full_i(fifo_full),
		.wr_en_o(fifo_wr_en),
		.wr_data_o(fifo_wr_data)
	);

endmodule

`default_nettype wire

// File: logic/minimac_ctlif.sv
////////////////////
// minimac control interface
// csr bank, receive slot bookkeeping, byte and drop
// counters, receive interrupt
////////////////////
`default_nettype none

module minimac_ctlif #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input wire logic sys_clk,
	input wire logic reset_i,

	input wire minimac_pkg::csr_addr_t csr_a_i,
	input wire logic csr_we_i,
	input wire minimac_pkg::csr_data_t csr_di_i,
	output minimac_pkg::csr_data_t csr_do_o,

	output logic irq_rx_o,

	output logic rx_rst_o,
	output logic promisc_o,
	output minimac_pkg::mac_addr_t macaddr_o,

	output logic rx_valid_o,
	output minimac_pkg::word_addr_t rx_adr_o,
	input wire logic rx_resetcount_i,
	input wire logic rx_incrcount_i,
	input wire logic rx_endframe_i,
	input wire logic rx_drop_i
);
	import minimac_pkg::*;

	logic csr_sel;
	logic csr_wr;
	logic [15:0] mac_hi;
	logic [31:0] mac_lo;
	word_addr_t slot_adr;
	logic slot_armed;
	logic frame_done;
	byte_count_t count;
	logic [15:0] drops;

	// block is selected by the top address bits
	assign csr_sel = (csr_a_i[13:10] == csr_addr);
	assign csr_wr = csr_sel & csr_we_i;

	assign macaddr_o = {mac_hi, mac_lo};
	assign rx_valid_o = slot_armed;
	assign rx_adr_o = slot_adr;
	// level interrupt held until software acks frame done
	assign irq_rx_o = frame_done;

	// station address and slot base
	always_ff @(posedge sys_clk) begin
		if (csr_wr && csr_a_i[3:0] == REG_MAC_HI)
			mac_hi <= csr_di_i[15:0];
		if (csr_wr && csr_a_i[3:0] == REG_MAC_LO)
			mac_lo <= csr_di_i;
		if (csr_wr && csr_a_i[3:0] == REG_SLOT_ADR)
			slot_adr <= csr_di_i[29:0];
	end

	always_ff @(posedge sys_clk) begin
		if (reset_i) begin
			rx_rst_o <= 1'b0;
			promisc_o <= 1'b0;
			slot_armed <= 1'b0;
			frame_done <= 1'b0;
			count <= '0;
			drops <= '0;
		end else begin
			// engine events first so that a csr write in the same cycle wins
			if (rx_endframe_i) begin
				slot_armed <= 1'b0;
				frame_done <= 1'b1;
			end
			if (rx_resetcount_i)
				count <= '0;
			else if (rx_incrcount_i)
				count <= count + 1'b1;
			// saturate instead of wrapping
			if (rx_drop_i && drops != 16'hffff)
				drops <= drops + 1'b1;

			if (csr_wr) begin
				case (csr_a_i[3:0])
					REG_CTRL: begin
						rx_rst_o <= csr_di_i[0];
						promisc_o <= csr_di_i[1];
					end
					// new slot base arms the receiver
					REG_SLOT_ADR: slot_armed <= 1'b1;
					// write one to clear frame done
					REG_STATUS: if (csr_di_i[1]) frame_done <= 1'b0;
					REG_DROPS: drops <= '0;
					default: ;
				endcase
			end
		end
	end

	// read data is registered and reads zero when the block is not selected
	always_ff @(posedge sys_clk) begin
		if (reset_i) begin
			csr_do_o <= '0;
		end else begin
			csr_do_o <= '0;
			if (csr_sel) begin
				case (csr_a_i[3:0])
					REG_CTRL: csr_do_o <= {30'd0, promisc_o, rx_rst_o};
					REG_MAC_HI: csr_do_o <= {16'd0, mac_hi};
					REG_MAC_LO: csr_do_o <= mac_lo;
					REG_SLOT_ADR: csr_do_o <= {2'b00, slot_adr};
					REG_COUNT: csr_do_o <= {21'd0, count};
					REG_STATUS: csr_do_o <= {30'd0, frame_done, slot_armed};
					REG_DROPS: csr_do_o <= {16'd0, drops};
					default: csr_do_o <= '0;
				endcase
			end
		end
	end

	// the engine reports a frame as stored or as dropped but never both
	a_end_drop_excl: assert property (@(posedge sys_clk) disable iff (reset_i)
		!(rx_endframe_i && rx_drop_i));

endmodule

`default_nettype wire

// File: logic/minimac_pkg.sv
////////////////////
// minimac shared definitions
// widths, register map, FIFO sizing and FSM encodings
// used by the receive MAC
////////////////////
`default_nettype none

package minimac_pkg;

	// csr bus
	typedef logic [31:0] csr_data_t;
	typedef logic [13:0] csr_addr_t;

	// station address and dma targets
	typedef logic [47:0] mac_addr_t;
	typedef logic [29:0] word_addr_t;
	typedef logic [10:0] byte_count_t;
	typedef logic [7:0] rx_byte_t;

	// fifo entry: bit 9 error, bit 8 last, bits 7..0 byte
	typedef logic [9:0] fifo_entry_t;
	localparam int FE_ERR = 9;
	localparam int FE_LAST = 8;

	// register index, taken from csr_a[3:0]
	localparam logic [3:0] REG_CTRL = 4'd0;
	localparam logic [3:0] REG_MAC_HI = 4'd1;
	localparam logic [3:0] REG_MAC_LO = 4'd2;
	localparam logic [3:0] REG_SLOT_ADR = 4'd3;
	localparam logic [3:0] REG_COUNT = 4'd4;
	localparam logic [3:0] REG_STATUS = 4'd5;
	localparam logic [3:0] REG_DROPS = 4'd6;

	// slot size, longer frames are aborted
	localparam byte_count_t RX_MAX_BYTES = 11'd1536;

	// clock crossing fifo, 16 entries
	localparam int FIFO_DEPTH_LOG2 = 4;
	localparam int FIFO_DEPTH = 1 << FIFO_DEPTH_LOG2;
	// one extra bit tells full from empty
	typedef logic [FIFO_DEPTH_LOG2:0] fifo_ptr_t;

	localparam mac_addr_t MAC_BROADCAST = 48'hffff_ffff_ffff;
	// second nibble of the 0xd5 start delimiter, low nibble first
	localparam logic [3:0] SFD_NIBBLE = 4'hd;

	typedef enum logic [2:0] {IDLE, HEADER, BODY, FLUSH, DISCARD} rx_state_t;
	typedef enum logic [1:0] {WAIT_SFD, DATA, ABORT} framer_state_t;

endpackage

`default_nettype wire

// File: logic/minimac_rx.sv
////////////////////
// minimac receive engine
// pops bytes, filters on destination address, packs
// little endian words, writes them as wishbone master
////////////////////
`default_nettype none

module minimac_rx (
	input wire logic sys_clk,
	input wire logic reset_i,

	input wire logic rx_rst_i,
	input wire logic promisc_i,
	input wire minimac_pkg::mac_addr_t macaddr_i,
	input wire logic rx_valid_i,
	input wire minimac_pkg::word_addr_t rx_adr_i,

	input wire logic empty_i,
	input wire minimac_pkg::fifo_entry_t rd_data_i,
	output logic rd_en_o,

	output logic rx_resetcount_o,
	output logic rx_incrcount_o,
	output logic rx_endframe_o,
	output logic rx_drop_o,

	output logic [31:0] wbm_adr_o,
	output logic wbm_stb_o,
	input wire logic wbm_ack_i,
	output logic [31:0] wbm_dat_o
);
	import minimac_pkg::*;

	rx_state_t state;
	byte_count_t byte_idx;
	logic [31:0] word_q;
	logic [31:0] word_next;
	word_addr_t slot_word;
	mac_addr_t mac_shift;
	rx_byte_t rx_byte;
	logic rx_last;
	logic rx_err;
	logic match_uc;
	logic match_bc;
	logic hdr_uc;
	logic hdr_bc;
	logic accept;

	assign rx_byte = rd_data_i[7:0];
	assign rx_last = rd_data_i[FE_LAST];
	// flagged entry or slot overflow
	assign rx_err = rd_data_i[FE_ERR] | (byte_idx == RX_MAX_BYTES);

	// no pop while a write is outstanding, the fifo absorbs the stall
	assign rd_en_o = !empty_i && !wbm_stb_o &&
		(state == HEADER || state == BODY || state == DISCARD);

	// lane 0 starts a fresh word, upper lanes stay zero as padding
	assign word_next = (byte_idx[1:0] == 2'd0) ? {24'd0, rx_byte} :
		word_q | ({24'd0, rx_byte} << {byte_idx[1:0], 3'b000});
	assign slot_word = rx_adr_i + word_addr_t'(byte_idx[10:2]);

	// destination goes out msb byte first
	assign mac_shift = macaddr_i << {byte_idx[2:0], 3'b000};
	assign hdr_uc = match_uc && (rx_byte == mac_shift[47:40]);
	assign hdr_bc = match_bc && (rx_byte == MAC_BROADCAST[7:0]);
	assign accept = promisc_i | hdr_uc | hdr_bc;

	always_ff @(posedge sys_clk) begin
		if (reset_i) begin
			state <= IDLE;
			wbm_stb_o <= 1'b0;
			rx_resetcount_o <= 1'b0;
			rx_incrcount_o <= 1'b0;
			rx_endframe_o <= 1'b0;
			rx_drop_o <= 1'b0;
		end else begin
			rx_resetcount_o <= 1'b0;
			rx_incrcount_o <= 1'b0;
			rx_endframe_o <= 1'b0;
			rx_drop_o <= 1'b0;
			if (wbm_stb_o && wbm_ack_i)
				wbm_stb_o <= 1'b0;

			case (state)
				IDLE: begin
					// slot is still counted as armed during the endframe pulse
					if (!empty_i) begin
						if (rx_rst_i || !rx_valid_i || rx_endframe_o) begin
							state <= DISCARD;
						end else begin
							state <= HEADER;
							rx_resetcount_o <= 1'b1;
							byte_idx <= '0;
							match_uc <= 1'b1;
							match_bc <= 1'b1;
						end
					end
				end
				HEADER, BODY: begin
					if (rd_en_o && rx_err) begin
						if (rx_last) begin
							state <= IDLE;
							rx_drop_o <= 1'b1;
						end else begin
							state <= DISCARD;
						end
					end else if (rd_en_o) begin
						rx_incrcount_o <= 1'b1;
						byte_idx <= byte_idx + 1'b1;
						word_q <= word_next;
						// full word, or padded tail of an accepted frame
						if (byte_idx[1:0] == 2'd3 || (rx_last && state == BODY)) begin
							wbm_dat_o <= word_next;
							wbm_adr_o <= {slot_word, 2'b00};
							wbm_stb_o <= (state == BODY);
						end
						if (state == HEADER) begin
							match_uc <= hdr_uc;
							match_bc <= hdr_bc;
							if (rx_last) begin
								// ends inside the header, too short to keep
								state <= IDLE;
								rx_drop_o <= 1'b1;
							end else if (byte_idx[2:0] == 3'd5) begin
								// word 0 was held back until the verdict
								if (accept) begin
									state <= BODY;
									wbm_stb_o <= 1'b1;
								end else begin
									state <= DISCARD;
								end
							end
						end else if (rx_last) begin
							state <= FLUSH;
						end
					end
				end
				FLUSH: begin
					// last word acknowledged, frame is complete
					if (!wbm_stb_o || wbm_ack_i) begin
						state <= IDLE;
						rx_endframe_o <= 1'b1;
					end
				end
				DISCARD: begin
					if (rd_en_o && rx_last) begin
						state <= IDLE;
						rx_drop_o <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// classic wishbone: request stays put until acknowledged
	a_wb_hold: assert property (@(posedge sys_clk) disable iff (reset_i)
		wbm_stb_o && !wbm_ack_i |=> wbm_stb_o && $stable(wbm_adr_o) && $stable(wbm_dat_o));

endmodule

`default_nettype wire

// File: logic/minimac_rx_fifo.sv
////////////////////
// minimac receive fifo
// dual clock, first word fall through, gray coded
// pointers between phy_rx_clk and sys_clk
////////////////////
`default_nettype none

module minimac_rx_fifo (
	input wire logic wr_clk,
	input wire logic rd_clk,
	input wire logic reset_i,

	input wire logic wr_en_i,
	input wire minimac_pkg::fifo_entry_t wr_data_i,
	output logic full_o,

	input wire logic rd_en_i,
	output logic empty_o,
	output minimac_pkg::fifo_entry_t rd_data_o
);
	import minimac_pkg::*;

	fifo_entry_t mem [FIFO_DEPTH];
	logic wr_rst_meta;
	logic wr_rst;
	fifo_ptr_t wr_bin;
	fifo_ptr_t wr_bin_next;
	fifo_ptr_t wr_gray;
	fifo_ptr_t rd_gray_meta;
	fifo_ptr_t rd_gray_sync;
	fifo_ptr_t rd_bin;
	fifo_ptr_t rd_bin_next;
	fifo_ptr_t rd_gray;
	fifo_ptr_t wr_gray_meta;
	fifo_ptr_t wr_gray_sync;

	function automatic fifo_ptr_t to_gray(input fifo_ptr_t b);
		return b ^ (b >> 1);
	endfunction

	// write domain reset, two flops from sys_clk
	always_ff @(posedge wr_clk) begin
		wr_rst_meta <= reset_i;
		wr_rst <= wr_rst_meta;
	end

	assign wr_bin_next = wr_bin + fifo_ptr_t'(wr_en_i & ~full_o);

	always_ff @(posedge wr_clk) begin
		if (wr_rst) begin
			wr_bin <= '0;
			wr_gray <= '0;
			rd_gray_meta <= '0;
			rd_gray_sync <= '0;
			full_o <= 1'b0;
		end else begin
			wr_bin <= wr_bin_next;
			wr_gray <= to_gray(wr_bin_next);
			rd_gray_meta <= rd_gray;
			rd_gray_sync <= rd_gray_meta;
			// full when the top two gray bits differ and the rest match
			full_o <= to_gray(wr_bin_next) == {~rd_gray_sync[FIFO_DEPTH_LOG2 -: 2],
				rd_gray_sync[FIFO_DEPTH_LOG2-2:0]};
		end
	end

	always_ff @(posedge wr_clk) begin
		if (wr_en_i && !full_o)
			mem[wr_bin[FIFO_DEPTH_LOG2-1:0]] <= wr_data_i;
	end

	// read side lives in sys_clk, reset is already local
	assign rd_bin_next = rd_bin + fifo_ptr_t'(rd_en_i & ~empty_o);
	// head entry shown ahead, rd_en consumes it
	assign rd_data_o = mem[rd_bin[FIFO_DEPTH_LOG2-1:0]];

	always_ff @(posedge rd_clk) begin
		if (reset_i) begin
			rd_bin <= '0;
			rd_gray <= '0;
			wr_gray_meta <= '0;
			wr_gray_sync <= '0;
			empty_o <= 1'b1;
		end else begin
			rd_bin <= rd_bin_next;
			rd_gray <= to_gray(rd_bin_next);
			wr_gray_meta <= wr_gray;
			wr_gray_sync <= wr_gray_meta;
			empty_o <= to_gray(rd_bin_next) == wr_gray_sync;
		end
	end

endmodule

`default_nettype wire

// File: logic/minimac_rx_framer.sv
////////////////////
// minimac receive framer
// mii nibbles to bytes on phy_rx_clk, strips preamble
// and delimiter, pushes bytes with last and error flags
////////////////////
`default_nettype none

module minimac_rx_framer (
	input wire logic phy_rx_clk,
	input wire logic reset_i,

	input wire logic [3:0] phy_rx_data_i,
	input wire logic phy_dv_i,
	input wire logic phy_rx_er_i,

	input wire logic full_i,
	output logic wr_en_o,
	output minimac_pkg::fifo_entry_t wr_data_o
);
	import minimac_pkg::*;

	logic rst_meta;
	logic rst_sync;
	framer_state_t state;
	logic hi_phase;
	logic [3:0] lo_nib;
	rx_byte_t pend;
	logic have_pend;
	logic err;
	logic push_req;

	// reset comes from sys_clk and is brought over with two flops
	always_ff @(posedge phy_rx_clk) begin
		rst_meta <= reset_i;
		rst_sync <= rst_meta;
	end

	// one byte is held back until we know whether it is the last
	always_comb begin
		push_req = 1'b0;
		wr_data_o = {err, 1'b0, pend};
		case (state)
			DATA: begin
				if (!phy_dv_i) begin
					// dv fell so the held byte closes the frame
					push_req = have_pend;
					wr_data_o = {err, 1'b1, pend};
				end else if (hi_phase) begin
					// a new byte completes and releases the held one
					push_req = have_pend;
				end
			end
			ABORT: begin
				// terminator for a truncated frame
				push_req = !phy_dv_i;
				wr_data_o = {1'b1, 1'b1, 8'h00};
			end
			default: ;
		endcase
	end

	assign wr_en_o = push_req & ~full_i;

	always_ff @(posedge phy_rx_clk) begin
		if (rst_sync) begin
			state <= WAIT_SFD;
			hi_phase <= 1'b0;
			have_pend <= 1'b0;
			err <= 1'b0;
		end else begin
			case (state)
				WAIT_SFD: begin
					// preamble nibbles are 5 and the delimiter ends on d
					if (phy_dv_i && phy_rx_data_i == SFD_NIBBLE) begin
						state <= DATA;
						hi_phase <= 1'b0;
						have_pend <= 1'b0;
						err <= 1'b0;
					end
				end
				DATA: begin
					if (push_req && full_i) begin
						// no room so the rest of the frame is dropped
						state <= ABORT;
					end else if (!phy_dv_i) begin
						// a dangling odd nibble is ignored
						state <= WAIT_SFD;
					end else begin
						err <= err | phy_rx_er_i;
						hi_phase <= ~hi_phase;
						if (hi_phase)
							have_pend <= 1'b1;
					end
				end
				ABORT: begin
					// leave once the frame is over and the terminator went in
					if (!phy_dv_i && !full_i)
						state <= WAIT_SFD;
				end
				default: state <= WAIT_SFD;
			endcase
		end
	end

	// nibble assembly with the low nibble first on the wire
	always_ff @(posedge phy_rx_clk) begin
		if (state == DATA && phy_dv_i) begin
			if (hi_phase)
				pend <= {phy_rx_data_i, lo_nib};
			else
				lo_nib <= phy_rx_data_i;
		end
	end

endmodule

`default_nettype wire

// File: minimac.f
logic/minimac_pkg.sv
logic/minimac_ctlif.sv
logic/minimac_rx_framer.sv
logic/minimac_rx_fifo.sv
logic/minimac_rx.sv
logic/minimac.sv
bench/minimac_tb.sv
